/* design/rv32_isa_pkg.sv */
// RV32I base ISA definitions for the fetch front end
// Machine word type, major opcodes, immediate widths and the reset vector

`default_nettype none

package rv32_isa_pkg;

    // Machine word width
    localparam int XLEN = 32;

    // Major opcode field, bits [6:0] of every 32-bit instruction
    localparam int OPCODE_W = 7;

    // Sign-extended immediate widths, the implicit zero LSB included
    localparam int IMM_B_W = 13;
    localparam int IMM_J_W = 21;

    // PCs, instructions and bus addresses
    typedef logic [XLEN-1:0] word_t;

    // Only the opcodes the front end cares about
    typedef enum logic [OPCODE_W-1:0] {
        OP_IMM = 7'b0010011,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } opcode_t;

    // First fetch address after reset
    localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

/* design/fetch_pipe_pkg.sv */
// Fetch/execute pipeline types
// Holds the record passed to execute and the result class of a fetch

`default_nettype none

package fetch_pipe_pkg;

    import rv32_isa_pkg::*;

    // Outcome of one instruction fetch, as reported by the fetch unit
    typedef enum logic [1:0] {
        FS_OK         = 2'b00,
        FS_MISALIGNED = 2'b01,
        FS_BUS_FAULT  = 2'b10
    } fetch_status_t;

    // Fetch/execute pipeline register contents
    // A faulting entry is valid with instr zeroed and one fault bit set
    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pc;
        word_t pc4;
        logic  pred_taken;
        word_t pred_addr;
        logic  mal_insn;
        logic  fault_insn;
    } fetch_ex_t;

endpackage

`default_nettype wire

/* design/imem_bus_if.sv */
// Instruction-memory bus with a four-phase req/ack handshake
// Master raises req with a stable addr, slave answers with ack, rdata and err,
// master drops req, slave drops ack

`timescale 1ns/1ps
`default_nettype none

interface imem_bus_if import rv32_isa_pkg::*; ();

    logic  req;
    word_t addr;
    logic  ack;
    word_t rdata;
    logic  err;

    modport master (
        output req,
        output addr,
        input  ack,
        input  rdata,
        input  err
    );

    modport slave (
        input  req,
        input  addr,
        output ack,
        output rdata,
        output err
    );

endinterface

`default_nettype wire

/* design/predictor_if.sv */
// Link between the fetch stage and the branch predictor
// The predictor answers combinationally within the same cycle

`timescale 1ns/1ps
`default_nettype none

interface predictor_if import rv32_isa_pkg::*; ();

    word_t pc;
    word_t instr;
    logic  predict_taken;
    word_t target_addr;

    modport stage (
        output pc,
        output instr,
        input  predict_taken,
        input  target_addr
    );

    modport predictor (
        input  pc,
        input  instr,
        output predict_taken,
        output target_addr
    );

endinterface

`default_nettype wire

/* design/instr_fetch_unit.sv */
// Instruction fetch unit
// Runs one four-phase transfer per instruction and holds the result until
// the stage consumes it. Misaligned PCs never reach the bus, and data from
// a transfer that was overtaken by a redirect is dropped

`timescale 1ns/1ps
`default_nettype none

module instr_fetch_unit
    import rv32_isa_pkg::*;
    import fetch_pipe_pkg::*;
(
    input  logic          CLK,
    input  logic          nRST,
    input  word_t         fetch_pc,
    input  logic          redirect,
    input  logic          consume,
    imem_bus_if.master    bus,
    output logic          insn_ready,
    output word_t         insn,
    output fetch_status_t status,
    output logic          busy
);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT_REL,
        HOLD
    } state_t;

    state_t        state;
    state_t        next_state;
    word_t         addr_q;
    word_t         insn_q;
    fetch_status_t status_q;
    logic          discard_q;
    logic          misaligned;

    assign misaligned = fetch_pc[1:0] != 2'b00;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // Wait one cycle after a redirect so fetch_pc is the new one
                if (!redirect && !bus.ack) begin
                    next_state = misaligned ? HOLD : REQUEST;
                end
            end
            REQUEST: begin
                if (bus.ack) begin
                    next_state = WAIT_REL;
                end
            end
            WAIT_REL: begin
                if (!bus.ack) begin
                    next_state = (discard_q || redirect) ? IDLE : HOLD;
                end
            end
            HOLD: begin
                if (consume || redirect) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            discard_q <= 1'b0;
        end else begin
            state <= next_state;
            if (next_state == IDLE) begin
                discard_q <= 1'b0;
            end else if (redirect && (state == REQUEST || state == WAIT_REL)) begin
                discard_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == IDLE && next_state == REQUEST) begin
            addr_q <= fetch_pc;
        end
        if (state == IDLE && next_state == HOLD) begin
            insn_q   <= '0;
            status_q <= FS_MISALIGNED;
        end
        // Sample the slave's answer on ack
        if (state == REQUEST && bus.ack) begin
            insn_q   <= bus.rdata;
            status_q <= bus.err ? FS_BUS_FAULT : FS_OK;
        end
    end

    assign bus.req    = state == REQUEST;
    assign bus.addr   = addr_q;
    assign insn_ready = state == HOLD;
    assign insn       = insn_q;
    assign status     = status_q;
    assign busy       = !insn_ready;

    // Address must not move under an open request
    a_addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
        bus.req && $past(bus.req) |-> $stable(bus.addr));

    // New request only once the slave has released ack
    a_req_after_ack: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(bus.req) |-> !$past(bus.ack));

endmodule

`default_nettype wire

/* design/branch_predictor.sv */
// Static branch predictor
// Backward conditional branches and JAL are predicted taken, forward
// branches are not, and JALR is never predicted

`timescale 1ns/1ps
`default_nettype none

module branch_predictor
    import rv32_isa_pkg::*;
(
    predictor_if.predictor pred
);

    opcode_t              opcode;
    logic [IMM_B_W-1:0]   imm_b;
    logic [IMM_J_W-1:0]   imm_j;
    word_t                imm_b_ext;
    word_t                imm_j_ext;
    word_t                pc4;

    assign opcode = opcode_t'(pred.instr[OPCODE_W-1:0]);

    // B-type immediate scattered over the upper and rd fields
    assign imm_b = {pred.instr[31], pred.instr[7], pred.instr[30:25],
                    pred.instr[11:8], 1'b0};

    // J-type immediate
    assign imm_j = {pred.instr[31], pred.instr[19:12], pred.instr[20],
                    pred.instr[30:21], 1'b0};

    assign imm_b_ext = {{(XLEN-IMM_B_W){imm_b[IMM_B_W-1]}}, imm_b};
    assign imm_j_ext = {{(XLEN-IMM_J_W){imm_j[IMM_J_W-1]}}, imm_j};
    assign pc4       = pred.pc + 32'd4;

    always_comb begin
        pred.predict_taken = 1'b0;
        pred.target_addr   = pc4;
        case (opcode)
            JAL: begin
                pred.predict_taken = 1'b1;
                pred.target_addr   = pred.pc + imm_j_ext;
            end
            BRANCH: begin
                // Negative offset means a loop, so guess taken
                if (imm_b[IMM_B_W-1]) begin
                    pred.predict_taken = 1'b1;
                    pred.target_addr   = pred.pc + imm_b_ext;
                end
            end
            JALR: begin
                // Target lives in a register, left to execute
                pred.predict_taken = 1'b0;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
// Instruction fetch stage
// Keeps the PC, picks the next PC (execute redirect, then prediction, then
// PC+4), folds fetch faults into the entry and loads the fetch/execute
// pipeline register under stall and flush

`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import rv32_isa_pkg::*;
    import fetch_pipe_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    input  logic       stall,
    input  logic       flush,
    input  logic       redirect_en,
    input  word_t      redirect_addr,
    imem_bus_if.master bus,
    output fetch_ex_t  fetch_ex,
    output logic       mem_busy
);

    word_t         pc;
    word_t         pc4;
    word_t         npc;
    word_t         insn;
    word_t         instr_to_ex;
    fetch_status_t status;
    logic          insn_ready;
    logic          busy;
    logic          advance;
    logic          squash;
    logic          pred_taken;
    word_t         pred_addr;
    logic          mis_redirect_q;
    fetch_ex_t     entry;

    predictor_if pred_if ();

    instr_fetch_unit fetcher (
        .CLK        (CLK),
        .nRST       (nRST),
        .fetch_pc   (pc),
        .redirect   (redirect_en),
        .consume    (advance),
        .bus        (bus),
        .insn_ready (insn_ready),
        .insn       (insn),
        .status     (status),
        .busy       (busy)
    );

    branch_predictor predictor (
        .pred (pred_if)
    );

    // Flush also holds the ready instruction so no PC is skipped
    assign advance = insn_ready && !stall && !redirect_en && !flush;

    assign squash      = status != FS_OK;
    assign instr_to_ex = squash ? '0 : insn;
    assign pc4         = pc + 32'd4;

    assign pred_if.pc    = pc;
    assign pred_if.instr = insn;

    // No prediction for an instruction that never arrived
    assign pred_taken = pred_if.predict_taken && !squash;
    assign pred_addr  = pred_taken ? pred_if.target_addr : pc4;

    always_comb begin
        if (redirect_en) begin
            npc = redirect_addr;
        end else if (advance) begin
            npc = pred_addr;
        end else begin
            npc = pc;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= RESET_PC;
        end else begin
            pc <= npc;
        end
    end

    always_comb begin
        entry            = '0;
        entry.valid      = 1'b1;
        entry.instr      = instr_to_ex;
        entry.pc         = pc;
        entry.pc4        = pc4;
        entry.pred_taken = pred_taken;
        entry.pred_addr  = pred_addr;
        entry.mal_insn   = status == FS_MISALIGNED;
        entry.fault_insn = status == FS_BUS_FAULT;
    end

    // Redirect, flush and an empty fetch all leave a bubble behind
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fetch_ex <= '0;
        end else if (!stall) begin
            fetch_ex <= advance ? entry : '0;
        end
    end

    assign mem_busy = busy;

    // Remembers whether the last redirect pointed off a word boundary
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mis_redirect_q <= 1'b0;
        end else if (redirect_en) begin
            mis_redirect_q <= redirect_addr[1:0] != 2'b00;
        end
    end

    a_pc_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        advance && !mis_redirect_q |=> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* design/fetch_top.sv */
// Fetch front end top level
// Wraps the fetch stage and exposes the instruction bus and the
// fetch/execute register as plain ports

`timescale 1ns/1ps
`default_nettype none

module fetch_top
    import rv32_isa_pkg::*;
    import fetch_pipe_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    input  logic  stall,
    input  logic  flush,
    input  logic  redirect_en,
    input  word_t redirect_addr,
    input  logic  imem_ack,
    input  word_t imem_rdata,
    input  logic  imem_err,
    output logic  imem_req,
    output word_t imem_addr,
    output logic  fe_valid,
    output word_t fe_instr,
    output word_t fe_pc,
    output word_t fe_pc4,
    output logic  fe_pred_taken,
    output word_t fe_pred_addr,
    output logic  fe_mal_insn,
    output logic  fe_fault_insn,
    output logic  mem_busy
);

    fetch_ex_t fetch_ex;

    imem_bus_if imem ();

    fetch_stage stage (
        .CLK           (CLK),
        .nRST          (nRST),
        .stall         (stall),
        .flush         (flush),
        .redirect_en   (redirect_en),
        .redirect_addr (redirect_addr),
        .bus           (imem),
        .fetch_ex      (fetch_ex),
        .mem_busy      (mem_busy)
    );

    // Slave side of the bus comes from outside
    assign imem.ack   = imem_ack;
    assign imem.rdata = imem_rdata;
    assign imem.err   = imem_err;
    assign imem_req   = imem.req;
    assign imem_addr  = imem.addr;

    assign fe_valid      = fetch_ex.valid;
    assign fe_instr      = fetch_ex.instr;
    assign fe_pc         = fetch_ex.pc;
    assign fe_pc4        = fetch_ex.pc4;
    assign fe_pred_taken = fetch_ex.pred_taken;
    assign fe_pred_addr  = fetch_ex.pred_addr;
    assign fe_mal_insn   = fetch_ex.mal_insn;
    assign fe_fault_insn = fetch_ex.fault_insn;

endmodule

`default_nettype wire

/* test/fetch_checker.sv */
// Fetch stream checker
// Follows the expected PC through the program image, compares each new
// fetch/execute entry with a reference model and watches the bus handshake

`timescale 1ns/1ps
`default_nettype none

module fetch_checker
    import rv32_isa_pkg::*;
#(
    parameter int    IDX_W    = 8,
    parameter word_t FAULT_LO = 32'h0000_0300,
    parameter word_t FAULT_HI = 32'h0000_0340
)
(
    input  logic  CLK,
    input  logic  nRST,
    input  logic  stall,
    input  logic  flush,
    input  logic  redirect_en,
    input  word_t redirect_addr,
    input  logic  imem_req,
    input  logic  imem_ack,
    input  word_t imem_addr,
    input  logic  mem_busy,
    input  logic  fe_valid,
    input  word_t fe_instr,
    input  word_t fe_pc,
    input  word_t fe_pc4,
    input  logic  fe_pred_taken,
    input  word_t fe_pred_addr,
    input  logic  fe_mal_insn,
    input  logic  fe_fault_insn,
    input  word_t mem [2**IDX_W],
    output int    errors,
    output int    checked,
    output int    mal_seen,
    output int    fault_seen
);

    int           error_count = 0;
    int           entry_count = 0;
    int           mal_count = 0;
    int           fault_count = 0;
    word_t        exp_pc = RESET_PC;
    logic         edge_stall = 1'b0;
    logic         edge_flush = 1'b0;
    logic         edge_redir = 1'b0;
    word_t        edge_raddr = '0;
    logic         edge_busy = 1'b1;
    logic         last_req = 1'b0;
    logic         last_ack = 1'b0;
    word_t        last_addr = '0;
    logic [131:0] snap;
    logic [131:0] prev_snap = '0;

    assign errors     = error_count;
    assign checked    = entry_count;
    assign mal_seen   = mal_count;
    assign fault_seen = fault_count;

    // Reference model of one fetch; the next PC is always the predicted address
    function automatic void model_fetch(
        input  word_t pc,
        output word_t instr,
        output logic  taken,
        output word_t target,
        output logic  mal,
        output logic  fault
    );
        word_t insn;
        word_t b_off;
        word_t j_off;
        insn   = mem[pc[IDX_W+1:2]];
        instr  = insn;
        taken  = 1'b0;
        target = pc + 32'd4;
        mal    = pc[1:0] != 2'b00;
        fault  = !mal && pc >= FAULT_LO && pc < FAULT_HI;
        b_off  = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
        j_off  = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
        if (mal || fault) begin
            instr = '0;
        end else if (insn[6:0] == JAL) begin
            taken  = 1'b1;
            target = pc + j_off;
        end else if (insn[6:0] == BRANCH && insn[31]) begin
            // Backward branch
            taken  = 1'b1;
            target = pc + b_off;
        end
    endfunction

    task automatic compare_field(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            error_count++;
            $display("MISMATCH at %0t: %s is %h, expected %h (pc %h)",
                     $time, name, got, want, exp_pc);
        end
    endtask

    task automatic check_entry();
        word_t e_instr;
        logic  e_taken;
        word_t e_target;
        logic  e_mal;
        logic  e_fault;
        model_fetch(exp_pc, e_instr, e_taken, e_target, e_mal, e_fault);
        compare_field("fe_pc", fe_pc, exp_pc);
        compare_field("fe_instr", fe_instr, e_instr);
        compare_field("fe_pc4", fe_pc4, exp_pc + 32'd4);
        compare_field("fe_pred_taken", 32'(fe_pred_taken), 32'(e_taken));
        compare_field("fe_pred_addr", fe_pred_addr, e_target);
        compare_field("fe_mal_insn", 32'(fe_mal_insn), 32'(e_mal));
        compare_field("fe_fault_insn", 32'(fe_fault_insn), 32'(e_fault));
        entry_count++;
        mal_count   += int'(e_mal);
        fault_count += int'(e_fault);
        exp_pc = e_target;
    endtask

    // Controls as the DUT saw them, plus the bus handshake rules
    always @(posedge CLK) begin
        edge_stall = stall;
        edge_flush = flush;
        edge_redir = redirect_en;
        edge_raddr = redirect_addr;
        edge_busy  = mem_busy;
        if (nRST) begin
            if (imem_req && !last_req && last_ack) begin
                error_count++;
                $display("Protocol error at %0t: imem_req rose while imem_ack was high", $time);
            end
            if (imem_req && last_req && imem_addr !== last_addr) begin
                error_count++;
                $display("Protocol error at %0t: imem_addr moved during a request", $time);
            end
            if (imem_req && imem_addr[1:0] != 2'b00) begin
                error_count++;
                $display("Protocol error at %0t: request to misaligned %h", $time, imem_addr);
            end
        end
        last_req  = imem_req;
        last_ack  = imem_ack;
        last_addr = imem_addr;
    end

    // Register outputs are settled half a cycle after the edge
    always @(negedge CLK) begin
        if (nRST) begin
            snap = {fe_valid, fe_instr, fe_pc, fe_pc4, fe_pred_taken, fe_pred_addr,
                    fe_mal_insn, fe_fault_insn};
            if (edge_stall) begin
                if (snap !== prev_snap) begin
                    error_count++;
                    $display("MISMATCH at %0t: outputs changed under stall", $time);
                end
            end else if (edge_redir || edge_flush) begin
                if (fe_valid) begin
                    error_count++;
                    $display("MISMATCH at %0t: valid entry after flush or redirect", $time);
                end
            end else begin
                // A ready instruction must move on exactly when mem_busy was low
                if (fe_valid !== !edge_busy) begin
                    error_count++;
                    $display("MISMATCH at %0t: fe_valid is %b but mem_busy was %b",
                             $time, fe_valid, edge_busy);
                end
                if (fe_valid) begin
                    check_entry();
                end
            end
            if (edge_redir) begin
                exp_pc = edge_raddr;
            end
            prev_snap = snap;
        end
    end

endmodule

`default_nettype wire

/* test/tb_fetch_top.sv */
// Testbench for the fetch front end
// Drives random stall, flush and redirect traffic, answers the instruction
// bus from a random program image and leaves the comparing to the checker

`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top
    import rv32_isa_pkg::*;
();

    localparam int    IDX_W          = 8;
    localparam int    MEM_DEPTH      = 1 << IDX_W;
    localparam word_t FAULT_LO       = 32'h0000_0300;
    localparam word_t FAULT_HI       = 32'h0000_0340;
    localparam int    RNG_SEED       = 32'h71cd_2966;
    localparam int    TARGET_ENTRIES = 600;
    localparam int    RUN_LIMIT      = 20000;
    localparam int    REQ_WAIT       = 1000;
    localparam int    ACK_WAIT       = 20;

    logic        CLK = 1'b0;
    logic        nRST;
    logic        stall;
    logic        flush;
    logic        redirect_en;
    word_t       redirect_addr;
    logic        imem_ack;
    word_t       imem_rdata;
    logic        imem_err;
    logic        imem_req;
    word_t       imem_addr;
    logic        fe_valid;
    word_t       fe_instr;
    word_t       fe_pc;
    word_t       fe_pc4;
    logic        fe_pred_taken;
    word_t       fe_pred_addr;
    logic        fe_mal_insn;
    logic        fe_fault_insn;
    logic        mem_busy;
    word_t       mem [MEM_DEPTH];
    int          errors;
    int          checked;
    int          mal_seen;
    int          fault_seen;
    int          cycles;
    logic        bus_stuck = 1'b0;

    always #10 CLK = ~CLK;

    fetch_top UUT (
        .CLK (CLK), .nRST (nRST), .stall (stall), .flush (flush),
        .redirect_en (redirect_en), .redirect_addr (redirect_addr),
        .imem_ack (imem_ack), .imem_rdata (imem_rdata), .imem_err (imem_err),
        .imem_req (imem_req), .imem_addr (imem_addr),
        .fe_valid (fe_valid), .fe_instr (fe_instr), .fe_pc (fe_pc), .fe_pc4 (fe_pc4),
        .fe_pred_taken (fe_pred_taken), .fe_pred_addr (fe_pred_addr),
        .fe_mal_insn (fe_mal_insn), .fe_fault_insn (fe_fault_insn), .mem_busy (mem_busy)
    );

    fetch_checker #(.IDX_W (IDX_W), .FAULT_LO (FAULT_LO), .FAULT_HI (FAULT_HI)) chk (
        .CLK (CLK), .nRST (nRST), .stall (stall), .flush (flush),
        .redirect_en (redirect_en), .redirect_addr (redirect_addr),
        .imem_req (imem_req), .imem_ack (imem_ack), .imem_addr (imem_addr),
        .mem_busy (mem_busy),
        .fe_valid (fe_valid), .fe_instr (fe_instr), .fe_pc (fe_pc), .fe_pc4 (fe_pc4),
        .fe_pred_taken (fe_pred_taken), .fe_pred_addr (fe_pred_addr),
        .fe_mal_insn (fe_mal_insn), .fe_fault_insn (fe_fault_insn), .mem (mem),
        .errors (errors), .checked (checked), .mal_seen (mal_seen), .fault_seen (fault_seen)
    );

    function automatic word_t encode_branch(int offset, word_t r);
        logic [12:0] imm;
        imm = offset[12:0];
        return {imm[12], imm[10:5], r[24:12], imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic word_t encode_jal(int offset, word_t r);
        logic [20:0] imm;
        imm = offset[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], r[11:7], JAL};
    endfunction

    // Half ALU words, the rest short forward and backward branches and jumps
    function automatic word_t random_instruction();
        int    kind;
        int    offset;
        word_t r;
        kind = int'($urandom % 20);
        r    = $urandom;
        if (kind < 10) begin
            return {r[31:7], OP_IMM};
        end else if (kind < 14) begin
            return encode_branch(4 * int'(1 + $urandom % 8), r);
        end else if (kind < 17) begin
            return encode_branch(-4 * int'(1 + $urandom % 8), r);
        end
        offset = 4 * (int'($urandom % 40) - 8);
        return encode_jal((offset == 0) ? 4 : offset, r);
    endfunction

    // Mostly aligned targets, some misaligned, some into the fault window
    function automatic word_t pick_redirect_target();
        int    kind;
        word_t base;
        kind = int'($urandom % 8);
        base = word_t'(($urandom % MEM_DEPTH) * 4);
        if (kind == 0) begin
            return base + word_t'(1 + $urandom % 3);
        end else if (kind == 1) begin
            return FAULT_LO + word_t'(($urandom % 16) * 4);
        end
        return base;
    endfunction

    task automatic drive_random_controls();
        stall       = ($urandom % 4) == 0;
        flush       = ($urandom % 20) == 0;
        redirect_en = ($urandom % 32) == 0;
        if (redirect_en) begin
            redirect_addr = pick_redirect_target();
        end
    endtask

    // One four-phase transfer, answered after 0 to 3 cycles
    task automatic serve_one_transfer();
        int waited;
        int delay;
        waited = 0;
        do begin
            @(negedge CLK);
            waited++;
        end while (!imem_req && waited < REQ_WAIT);
        if (!imem_req) begin
            $display("Bus responder: no request for %0d cycles", REQ_WAIT);
            bus_stuck = 1'b1;
        end else begin
            delay = int'($urandom % 4);
            repeat (delay) @(negedge CLK);
            imem_ack   = 1'b1;
            imem_rdata = mem[imem_addr[IDX_W+1:2]];
            imem_err   = imem_addr >= FAULT_LO && imem_addr < FAULT_HI;
            waited     = 0;
            while (imem_req && waited < ACK_WAIT) begin
                @(negedge CLK);
                waited++;
            end
            if (imem_req) begin
                $display("Bus responder: imem_req still high %0d cycles after ack", ACK_WAIT);
                bus_stuck = 1'b1;
            end
            imem_ack = 1'b0;
            imem_err = 1'b0;
        end
    endtask

    initial begin
        while (!bus_stuck) begin
            serve_one_transfer();
        end
    end

    initial begin
        nRST          = 1'b0;
        stall         = 1'b0;
        flush         = 1'b0;
        redirect_en   = 1'b0;
        redirect_addr = '0;
        imem_ack      = 1'b0;
        imem_rdata    = '0;
        imem_err      = 1'b0;
        void'($urandom(RNG_SEED));
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = random_instruction();
        end
        repeat (10) @(negedge CLK);
        nRST   = 1'b1;
        cycles = 0;
        while (checked < TARGET_ENTRIES && !bus_stuck && cycles < RUN_LIMIT) begin
            @(negedge CLK);
            drive_random_controls();
            cycles++;
            @(posedge CLK);
        end
        @(negedge CLK);
        stall       = 1'b0;
        flush       = 1'b0;
        redirect_en = 1'b0;
        @(posedge CLK);
        if (cycles >= RUN_LIMIT) begin
            $display("Timeout: only %0d of %0d entries arrived", checked, TARGET_ENTRIES);
        end
        $display("Summary: %0d entries checked, %0d misaligned, %0d bus faults, %0d errors",
                 checked, mal_seen, fault_seen, errors);
        if (errors == 0 && !bus_stuck && cycles < RUN_LIMIT) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
design/rv32_isa_pkg.sv
design/fetch_pipe_pkg.sv
design/imem_bus_if.sv
design/predictor_if.sv
design/instr_fetch_unit.sv
design/branch_predictor.sv
design/fetch_stage.sv
design/fetch_top.sv
test/fetch_checker.sv
test/tb_fetch_top.sv

/* Makefile */
# Verilator simulation of the fetch front end

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
